/* src/sram_vga_macros.svh */
`ifndef SRAM_VGA_MACROS_SVH
`define SRAM_VGA_MACROS_SVH

// external sram geometry
`define SRAM_DATA_BITS 16
`define SRAM_ADDR_BITS 18
`define BYTE_ADDR_BITS 19 // host and vga byte address

// small raster so a frame fits in a few hundred clocks
`define H_ACTIVE 16
`define H_FRONT 2
`define H_SYNC 3
`define H_TOTAL 24

`define V_ACTIVE 4
`define V_FRONT 1
`define V_SYNC 1
`define V_TOTAL 6

`define FB_BASE 0 // byte address of pixel (0,0)

`endif

/* src/sram_vga_pkg.sv */
`default_nettype none

package sram_vga_pkg;

	// what the pin driver does in the next cycle
	typedef enum logic [1:0] {
		OP_IDLE = 2'd0,
		OP_READ = 2'd1,
		OP_WRITE = 2'd2
	} sram_op_e;

	// owner of the read data currently on its way back
	typedef enum logic [1:0] {
		GRANT_NONE = 2'd0,
		GRANT_WB = 2'd1,
		GRANT_VGA = 2'd2
	} grant_e;

endpackage

`default_nettype wire

/* src/sram_port_if.sv */
`default_nettype none

`include "sram_vga_macros.svh"

interface sram_port_if import sram_vga_pkg::*; ();

	sram_op_e op; // one operation per clock, no handshake
	logic [`SRAM_ADDR_BITS-1:0] addr; // word address
	logic [7:0] wdata; // host byte, duplicated at the pins
	logic lsb; // byte lane of a write
	logic [`SRAM_DATA_BITS-1:0] rdata; // captured on the falling edge

	modport ctrl (
		output op, addr, wdata, lsb,
		input rdata
	);

	modport pins (
		input op, addr, wdata, lsb,
		output rdata
	);

endinterface

`default_nettype wire

/* src/sram_access_ctrl.sv */
`default_nettype none

`include "sram_vga_macros.svh"

module sram_access_ctrl import sram_vga_pkg::*; (
	input logic I_wb_clk,
	input logic reset,

	// wishbone host, byte wide
	input logic stb,
	input logic we,
	input logic [`BYTE_ADDR_BITS-1:0] adr,
	input logic [7:0] wb_dat_in,
	output logic [7:0] wb_dat_out,
	output logic ack,
	output logic stall,

	// scan-out read port
	input logic vga_req,
	input logic [`BYTE_ADDR_BITS-1:0] vga_adr,
	output logic [`SRAM_DATA_BITS-1:0] vga_dat,

	sram_port_if.ctrl sram
);

	sram_op_e op_nxt;
	grant_e grant_nxt;
	grant_e grant_q; // owner of the access now on the pins
	logic [`SRAM_ADDR_BITS-1:0] addr_nxt;
	logic lsb_nxt;
	logic lane_q; // byte lane of the access now on the pins
	logic wb_go;

	// vga always wins, host waits
	assign stall = stb & vga_req;
	assign wb_go = stb & ~vga_req;

	always_comb begin
		op_nxt = OP_IDLE;
		grant_nxt = GRANT_NONE;
		addr_nxt = adr[`BYTE_ADDR_BITS-1:1];
		lsb_nxt = adr[0];
		if (vga_req) begin
			op_nxt = OP_READ;
			grant_nxt = GRANT_VGA;
			addr_nxt = vga_adr[`BYTE_ADDR_BITS-1:1];
			lsb_nxt = vga_adr[0];
		end else if (stb) begin
			if (we) begin
				op_nxt = OP_WRITE; // no data comes back
			end else begin
				op_nxt = OP_READ;
				grant_nxt = GRANT_WB;
			end
		end
	end

	assign sram.op = op_nxt;
	assign sram.addr = addr_nxt;
	assign sram.lsb = lsb_nxt;
	assign sram.wdata = wb_dat_in;

	always_ff @(posedge I_wb_clk) begin
		if (reset) begin
			ack <= 1'b0;
			grant_q <= GRANT_NONE;
		end else begin
			ack <= wb_go; // one cycle after acceptance
			grant_q <= grant_nxt;
		end
	end

	always_ff @(posedge I_wb_clk) begin
		lane_q <= lsb_nxt;
		// the word was captured mid-cycle, hold it for the scan side
		if (grant_q == GRANT_VGA) begin
			vga_dat <= sram.rdata;
		end
	end

	// host byte comes straight off the capture register during ack
	always_comb begin
		wb_dat_out = 8'h00;
		if (grant_q == GRANT_WB) begin
			wb_dat_out = lane_q ? sram.rdata[15:8] : sram.rdata[7:0];
		end
	end

endmodule

`default_nettype wire

/* src/sram_pin_driver.sv */
`default_nettype none

`include "sram_vga_macros.svh"

module sram_pin_driver import sram_vga_pkg::*; (
	input logic I_wb_clk,
	input logic reset,

	sram_port_if.pins port,

	// asynchronous sram pins
	inout wire [`SRAM_DATA_BITS-1:0] data,
	output logic [`SRAM_ADDR_BITS-1:0] address,
	output logic oe_n,
	output logic ce_n,
	output logic we_n,
	output logic lb_n,
	output logic ub_n
);

	logic write_rise; // toggles on the rising edge to start a write
	logic write_fall; // catches up on the falling edge
	logic read_rise;
	logic read_fall;
	logic write_pulse;
	logic read_pulse;
	logic [`SRAM_DATA_BITS-1:0] wdata_q;
	logic [`SRAM_DATA_BITS-1:0] rdata_q;

	// high between the rising edge and the following falling edge
	assign write_pulse = write_rise ^ write_fall;
	assign read_pulse = read_rise ^ read_fall;

	assign we_n = ~write_pulse;
	assign oe_n = ~read_pulse;
	assign ce_n = 1'b0; // chip always selected

	// pins of the access issued last cycle
	always_ff @(posedge I_wb_clk) begin
		address <= port.addr;
		wdata_q <= {port.wdata, port.wdata}; // same byte on both lanes
	end

	always_ff @(posedge I_wb_clk) begin
		if (reset) begin
			write_rise <= 1'b0;
			read_rise <= 1'b0;
			lb_n <= 1'b1;
			ub_n <= 1'b1;
		end else begin
			case (port.op)
				OP_WRITE: begin
					write_rise <= ~write_fall;
					lb_n <= port.lsb; // even byte on the low lane
					ub_n <= ~port.lsb;
				end
				OP_READ: begin
					read_rise <= ~read_fall;
					lb_n <= 1'b0; // whole word
					ub_n <= 1'b0;
				end
				default: begin
					lb_n <= 1'b1;
					ub_n <= 1'b1;
				end
			endcase
		end
	end

	always_ff @(negedge I_wb_clk) begin
		if (reset) begin
			write_fall <= 1'b0;
			read_fall <= 1'b0;
		end else begin
			write_fall <= write_rise; // ends the strobe
			read_fall <= read_rise;
		end
	end

	// sample the bus just before oe_n goes back high
	always_ff @(negedge I_wb_clk) begin
		if (read_pulse) begin
			rdata_q <= data;
		end
	end

	assign data = write_pulse ? wdata_q : 'z;
	assign port.rdata = rdata_q;

endmodule

`default_nettype wire

/* src/vga_scan_fetch.sv */
`default_nettype none

`include "sram_vga_macros.svh"

module vga_scan_fetch (
	input logic I_wb_clk,
	input logic reset,

	// word fetch from the frame buffer
	output logic vga_req,
	output logic [`BYTE_ADDR_BITS-1:0] vga_adr,
	input logic [`SRAM_DATA_BITS-1:0] vga_dat,

	// display side
	output logic hsync,
	output logic vsync,
	output logic de,
	output logic [7:0] pixel
);

	localparam int HW = $clog2(`H_TOTAL);
	localparam int VW = $clog2(`V_TOTAL);
	localparam int AW = `BYTE_ADDR_BITS;

	logic [HW-1:0] hcnt;
	logic [HW-1:0] hcnt_nxt;
	logic [VW-1:0] vcnt;
	logic [VW-1:0] vcnt_nxt;
	logic h_wrap;
	logic v_wrap;
	logic active;
	logic hs_raw;
	logic vs_raw;
	logic de_d1;
	logic hs_d1;
	logic vs_d1;
	logic odd_d1; // column parity in the first delay stage
	logic [7:0] hi_q; // upper pixel of the latched word

	assign h_wrap = (hcnt == `H_TOTAL - 1);
	assign v_wrap = (vcnt == `V_TOTAL - 1);
	assign hcnt_nxt = h_wrap ? '0 : hcnt + 1'b1;
	assign vcnt_nxt = h_wrap ? (v_wrap ? '0 : vcnt + 1'b1) : vcnt;

	always_ff @(posedge I_wb_clk) begin
		if (reset) begin
			hcnt <= '0;
			vcnt <= '0;
		end else begin
			hcnt <= hcnt_nxt;
			vcnt <= vcnt_nxt;
		end
	end

	// fetch one cycle ahead of every even active column
	assign vga_req = (hcnt_nxt < `H_ACTIVE) && !hcnt_nxt[0] && (vcnt_nxt < `V_ACTIVE);
	assign vga_adr = AW'(`FB_BASE + vcnt_nxt * `H_ACTIVE + hcnt_nxt);

	assign active = (hcnt < `H_ACTIVE) && (vcnt < `V_ACTIVE);
	assign hs_raw = (hcnt >= `H_ACTIVE + `H_FRONT) &&
		(hcnt < `H_ACTIVE + `H_FRONT + `H_SYNC);
	assign vs_raw = (vcnt >= `V_ACTIVE + `V_FRONT) &&
		(vcnt < `V_ACTIVE + `V_FRONT + `V_SYNC);

	// two stage delay so the word is back before its pixels leave
	always_ff @(posedge I_wb_clk) begin
		if (reset) begin
			de_d1 <= 1'b0;
			hs_d1 <= 1'b0;
			vs_d1 <= 1'b0;
			de <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end else begin
			de_d1 <= active;
			hs_d1 <= hs_raw;
			vs_d1 <= vs_raw;
			de <= de_d1;
			hsync <= hs_d1;
			vsync <= vs_d1;
		end
	end

	always_ff @(posedge I_wb_clk) begin
		odd_d1 <= hcnt[0];
		if (de_d1 && !odd_d1) begin
			hi_q <= vga_dat[15:8]; // kept for the odd column
		end
		if (!de_d1) begin
			pixel <= 8'h00; // black in blanking
		end else if (odd_d1) begin
			pixel <= hi_q;
		end else begin
			pixel <= vga_dat[7:0]; // lower byte first
		end
	end

endmodule

`default_nettype wire

/* src/sram_vga_top.sv */
`default_nettype none

`include "sram_vga_macros.svh"

module sram_vga_top (
	input logic I_wb_clk,
	input logic reset,

	// wishbone host
	input logic stb,
	input logic we,
	input logic [`BYTE_ADDR_BITS-1:0] adr,
	input logic [7:0] wb_dat_in,
	output logic [7:0] wb_dat_out,
	output logic ack,
	output logic stall,

	// video out
	output logic hsync,
	output logic vsync,
	output logic de,
	output logic [7:0] pixel,

	// external sram
	inout wire [`SRAM_DATA_BITS-1:0] data,
	output logic [`SRAM_ADDR_BITS-1:0] address,
	output logic oe_n,
	output logic ce_n,
	output logic we_n,
	output logic lb_n,
	output logic ub_n
);

	logic vga_req;
	logic [`BYTE_ADDR_BITS-1:0] vga_adr;
	logic [`SRAM_DATA_BITS-1:0] vga_dat;

	sram_port_if sram_port ();

	sram_access_ctrl u_ctrl (
		.I_wb_clk (I_wb_clk),
		.reset (reset),
		.stb (stb),
		.we (we),
		.adr (adr),
		.wb_dat_in (wb_dat_in),
		.wb_dat_out (wb_dat_out),
		.ack (ack),
		.stall (stall),
		.vga_req (vga_req),
		.vga_adr (vga_adr),
		.vga_dat (vga_dat),
		.sram (sram_port.ctrl)
	);

	sram_pin_driver u_pins (
		.I_wb_clk (I_wb_clk),
		.reset (reset),
		.port (sram_port.pins),
		.data (data),
		.address (address),
		.oe_n (oe_n),
		.ce_n (ce_n),
		.we_n (we_n),
		.lb_n (lb_n),
		.ub_n (ub_n)
	);

	vga_scan_fetch u_scan (
		.I_wb_clk (I_wb_clk),
		.reset (reset),
		.vga_req (vga_req),
		.vga_adr (vga_adr),
		.vga_dat (vga_dat),
		.hsync (hsync),
		.vsync (vsync),
		.de (de),
		.pixel (pixel)
	);

endmodule

`default_nettype wire

/* sim/sram_async_model.sv */
`default_nettype none

`include "sram_vga_macros.svh"

module sram_async_model (
	inout wire [`SRAM_DATA_BITS-1:0] data,
	input logic [`SRAM_ADDR_BITS-1:0] address,
	input logic oe_n,
	input logic ce_n,
	input logic we_n,
	input logic lb_n,
	input logic ub_n
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DEPTH = 1 << `SRAM_ADDR_BITS;
	localparam int WRITE_SETTLE = 5; // well inside the 10 ns strobe

	logic [`SRAM_DATA_BITS-1:0] mem [DEPTH];

	// power-up contents, every address bit shows up in the word
	initial begin
		logic [`SRAM_ADDR_BITS-1:0] a;
		for (int i = 0; i < DEPTH; i++) begin
			a = i[`SRAM_ADDR_BITS-1:0];
			mem[i] = {a[7:0] ^ {6'b0, a[17:16]}, a[15:8]};
		end
	end

	// data is taken in the middle of the write strobe
	always @(negedge we_n) begin
		#WRITE_SETTLE;
		if (!we_n && !ce_n) begin
			if (!lb_n) begin
				mem[address][7:0] = data[7:0];
			end
			if (!ub_n) begin
				mem[address][15:8] = data[15:8]; // odd byte
			end
		end
	end

	// reads put the whole word out, lanes only gate writes
	assign data = (!ce_n && !oe_n && we_n) ? mem[address] : 'z;

endmodule

`default_nettype wire

/* sim/tb_sram_vga.sv */
`default_nettype none

`include "sram_vga_macros.svh"

module tb_sram_vga;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
	localparam int FRAME_PIXELS = `H_ACTIVE * `V_ACTIVE;
	localparam int MAX_CYCLES = 3 * FRAME_CYCLES + 400;
	localparam int SAMPLE_DLY = 15; // three quarters into the cycle

	logic I_wb_clk;
	logic reset;
	logic stb;
	logic we;
	logic [`BYTE_ADDR_BITS-1:0] adr;
	logic [7:0] wb_dat_in;
	logic [7:0] wb_dat_out;
	logic ack;
	logic stall;
	logic hsync;
	logic vsync;
	logic de;
	logic [7:0] pixel;
	wire [`SRAM_DATA_BITS-1:0] data;
	logic [`SRAM_ADDR_BITS-1:0] address;
	logic oe_n;
	logic ce_n;
	logic we_n;
	logic lb_n;
	logic ub_n;

	int cycles = 0;
	int checks = 0;
	int mismatches = 0;
	int failures = 0;
	int stalls = 0;
	integer seed;
	bit [7:0] shadow [int]; // expected byte per written address

	sram_vga_top DUT (
		.I_wb_clk (I_wb_clk), .reset (reset),
		.stb (stb), .we (we), .adr (adr), .wb_dat_in (wb_dat_in),
		.wb_dat_out (wb_dat_out), .ack (ack), .stall (stall),
		.hsync (hsync), .vsync (vsync), .de (de), .pixel (pixel),
		.data (data), .address (address), .oe_n (oe_n), .ce_n (ce_n),
		.we_n (we_n), .lb_n (lb_n), .ub_n (ub_n)
	);

	sram_async_model u_sram (
		.data (data), .address (address), .oe_n (oe_n), .ce_n (ce_n),
		.we_n (we_n), .lb_n (lb_n), .ub_n (ub_n)
	);

	initial I_wb_clk = 1'b0;
	always #10 I_wb_clk = ~I_wb_clk;

	task automatic print_summary();
		$display("checks %0d, mismatches %0d, other errors %0d, host stalls %0d",
			checks, mismatches, failures, stalls);
	endtask

	always @(posedge I_wb_clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			print_summary();
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			mismatches++;
			$display("mismatch at %0d ns: %s, expected %0h, got %0h",
				$time, what, expected, actual);
		end
	endtask

	task automatic wait_sample();
		@(posedge I_wb_clk);
		#SAMPLE_DLY;
	endtask

	function automatic int random_below(input int n);
		random_below = int'($unsigned($random(seed)) % n);
	endfunction

	// one host access, held through any stall, done at its ack
	task automatic host_access(input logic write, input logic [`BYTE_ADDR_BITS-1:0] a,
		input logic [7:0] wd, output logic [7:0] rd);
		@(posedge I_wb_clk);
		stb <= 1'b1;
		we <= write;
		adr <= a;
		wb_dat_in <= wd;
		#SAMPLE_DLY;
		check_value("ack before acceptance", 32'd0, 32'(ack));
		while (stall) begin
			stalls++;
			wait_sample();
			check_value("ack while stalled", 32'd0, 32'(ack));
		end
		@(posedge I_wb_clk); // accepted on this edge
		stb <= 1'b0;
		we <= 1'b0;
		#SAMPLE_DLY;
		check_value("ack after acceptance", 32'd1, 32'(ack));
		rd = wb_dat_out;
		check_value("stall with strobe low", 32'd0, 32'(stall));
		check_value("sram word address", 32'(a[`BYTE_ADDR_BITS-1:1]), 32'(address));
		if (write) begin
			// even byte on the low lane, odd byte on the high lane
			check_value("lb_n on write", 32'(a[0]), 32'(lb_n));
			check_value("ub_n on write", 32'(!a[0]), 32'(ub_n));
		end
		wait_sample();
		check_value("ack held past one cycle", 32'd0, 32'(ack));
	endtask

	task automatic host_write(input logic [`BYTE_ADDR_BITS-1:0] a, input logic [7:0] d);
		logic [7:0] unused_rd;
		host_access(1'b1, a, d, unused_rd);
		shadow[int'(a)] = d;
	endtask

	task automatic host_read_check(input logic [`BYTE_ADDR_BITS-1:0] a);
		logic [7:0] rd;
		host_access(1'b0, a, 8'h00, rd);
		check_value($sformatf("read byte at %0h", a), 32'(shadow[int'(a)]), 32'(rd));
	endtask

	task automatic test_reset_state();
		repeat (4) @(posedge I_wb_clk);
		@(posedge I_wb_clk);
		reset <= 1'b0; // fifth reset edge is this one
		#SAMPLE_DLY;
		check_value("ack after reset", 32'd0, 32'(ack));
		check_value("de after reset", 32'd0, 32'(de));
		check_value("hsync after reset", 32'd0, 32'(hsync));
		check_value("vsync after reset", 32'd0, 32'(vsync));
		check_value("we_n after reset", 32'd1, 32'(we_n));
		check_value("oe_n after reset", 32'd1, 32'(oe_n));
		check_value("ce_n tied low", 32'd0, 32'(ce_n));
	endtask

	// each lane overwritten in turn, its neighbour read back
	task automatic test_byte_lanes();
		logic [`BYTE_ADDR_BITS-1:0] base;
		for (int n = 0; n < 4; n++) begin
			base = `BYTE_ADDR_BITS'($random(seed));
			base[0] = 1'b0;
			host_write(base, 8'($random(seed)));
			host_write(base + 1'b1, 8'($random(seed)));
			host_write(base, 8'($random(seed)));
			host_read_check(base + 1'b1);
			host_read_check(base);
			host_write(base + 1'b1, 8'($random(seed)));
			host_read_check(base);
			host_read_check(base + 1'b1);
		end
	endtask

	task automatic test_frame_fill();
		for (int i = 0; i < FRAME_PIXELS; i++) begin
			host_write(`BYTE_ADDR_BITS'(`FB_BASE + i), 8'($random(seed)));
		end
	endtask

	task automatic test_scan_contention();
		int stalls_before;
		stalls_before = stalls;
		wait_sample();
		while (!de) wait_sample(); // start inside the active area
		for (int n = 0; n < 8; n++) begin
			host_read_check(`BYTE_ADDR_BITS'(`FB_BASE + random_below(FRAME_PIXELS)));
		end
		if (stalls == stalls_before) begin
			failures++;
			$display("error: no host read was stalled by a scan fetch during the active area");
		end
	endtask

	task automatic test_frame_scan();
		int idx;
		int hs_pulses;
		int vs_pulses;
		int hs_cycles;
		int vs_cycles;
		logic hs_prev;
		logic vs_prev;
		idx = 0;
		hs_pulses = 0;
		vs_pulses = 0;
		hs_cycles = 0;
		vs_cycles = 0;
		hs_prev = 1'b0;
		vs_prev = 1'b0;
		wait_sample();
		while (!vsync) wait_sample();
		while (vsync) wait_sample(); // now at pixel (0,0)
		for (int c = 0; c < FRAME_CYCLES; c++) begin
			if (c > 0) begin
				wait_sample();
			end
			if (de) begin
				if (idx < FRAME_PIXELS) begin
					check_value($sformatf("pixel %0d", idx),
						32'(shadow[`FB_BASE + idx]), 32'(pixel));
				end
				idx++;
			end
			if (hsync && !hs_prev) hs_pulses++;
			if (vsync && !vs_prev) vs_pulses++;
			if (hsync) hs_cycles++;
			if (vsync) vs_cycles++;
			hs_prev = hsync;
			vs_prev = vsync;
		end
		check_value("pixels per frame", 32'(FRAME_PIXELS), 32'(idx));
		check_value("hsync pulses per frame", 32'(`V_TOTAL), 32'(hs_pulses));
		check_value("vsync pulses per frame", 32'd1, 32'(vs_pulses));
		check_value("hsync cycles per frame", 32'(`V_TOTAL * `H_SYNC), 32'(hs_cycles));
		check_value("vsync cycles per frame", 32'(`V_SYNC * `H_TOTAL), 32'(vs_cycles));
	endtask

	initial begin
		seed = 32'hc8b2;
		reset <= 1'b1;
		stb <= 1'b0;
		we <= 1'b0;
		adr <= '0;
		wb_dat_in <= 8'h00;
		test_reset_state();
		test_byte_lanes();
		test_frame_fill();
		test_scan_contention();
		test_frame_scan();
		wait_sample();
		print_summary();
		if (mismatches == 0 && failures == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+src
src/sram_vga_pkg.sv
src/sram_port_if.sv
src/sram_access_ctrl.sv
src/sram_pin_driver.sv
src/vga_scan_fetch.sv
src/sram_vga_top.sv
sim/sram_async_model.sv
sim/tb_sram_vga.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile the frame buffer testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --timescale 1ns/1ps -f src.f \
	--top-module tb_sram_vga -o tb_sram_vga \
	&& ./obj_dir/tb_sram_vga > "$LOG" 2>&1 \
	|| { echo "build or simulation run failed"; cat "$LOG" 2>/dev/null; exit 1; }

cat "$LOG"
grep -q "TESTBENCH PASSED" "$LOG" && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
